/* build.f */
ahb_pkg.sv
soc_map_pkg.sv
ahb_addr_decoder.sv
ahb_sram_slave.sv
ahb_resp_mux.sv
ahb_fabric_top.sv
ahb_fabric_properties.sv
tb_ahb_fabric.sv

/* run_sim.sh */
#!/bin/sh
# build the AHB fabric testbench with Verilator, run it and search the log

LOG=sim.log

verilator --binary --timing --assert --top-module tb_ahb_fabric -f build.f \
   -o sim_ahb_fabric > "$LOG" 2>&1 &&
   ./obj_dir/sim_ahb_fabric >> "$LOG" 2>&1 ||
   echo "TEST FAILED" >> "$LOG"

cat "$LOG"

grep -q "TEST FAILED" "$LOG" && exit 1 || exit 0

/* tb_ahb_fabric.sv */
// AHB fabric testbench
// single bus master driven from a stimulus table, responses checked
// against a byte-lane model of the SRAM bank
`timescale 1ns/1ps
`default_nettype none

module tb_ahb_fabric;

   import ahb_pkg::*;

   localparam int NUM_SLAVES = 4;
   localparam int MEM_WORDS  = 64;
   localparam int WAIT_LIMIT = 20;   // stalled cycles before a data phase counts as hung

   typedef struct packed {
      haddr_t     addr;
      logic       write;
      hsize_t     size;
      hdata_t     wdata;
      logic [2:0] flags;   // random data, back to back, expect error
   } stim_t;

   logic     hclk_i;
   logic     rst_i;
   ahb_req_t req_i;
   ahb_rsp_t rsp_o;

   stim_t    tbl [$];
   string    tbl_name [$];
   hdata_t   model [NUM_SLAVES][MEM_WORDS];   // expected SRAM contents
   int       errors;
   int       timeouts;

   ahb_fabric_top #(
      .NUM_SLAVES ( NUM_SLAVES ),
      .MEM_WORDS  ( MEM_WORDS  )
   ) UUT (
      .hclk_i     ( hclk_i     ),
      .rst_i      ( rst_i      ),
      .req_i      ( req_i      ),
      .rsp_o      ( rsp_o      )
   );

   initial begin
      hclk_i = 1'b0;
      forever #2 hclk_i = ~hclk_i;
   end

   //////////////////////////////////////////////////////////////////////
   // helpers

   task automatic add_entry(input string name, input haddr_t addr, input logic write,
                            input hsize_t size, input hdata_t wdata, input logic [2:0] flags);
      stim_t e;
      e.addr  = addr;
      e.write = write;
      e.size  = size;
      e.wdata = flags[2] ? hdata_t'($urandom) : wdata;   // random data drawn once here
      e.flags = flags;
      tbl.push_back(e);
      tbl_name.push_back(name);
   endtask

   // byte lanes covered by a transfer of this size at this low address
   function automatic byte_en_t lanes(input hsize_t size, input logic [1:0] lo);
      byte_en_t be;
      int       nbytes;
      int       first;
      nbytes = 1 << size;                        // 1, 2 or 4 bytes
      first  = (int'(lo) / nbytes) * nbytes;     // lowest lane of the transfer
      for (int b = 0; b < 4; b++) begin
         be[b] = (b >= first) && (b < first + nbytes);
      end
      return be;
   endfunction

   task automatic check_value(input string name, input hdata_t expected, input hdata_t actual);
      if (actual !== expected) begin
         errors++;
         $display("** Error %s expected %h actual %h", name, expected, actual);
      end
   endtask

   // address phase of entry ap and write data of entry dp, -1 means none
   task automatic drive_bus(input int ap, input int dp);
      if (ap >= 0) begin
         req_i.haddr  <= tbl[ap].addr;
         req_i.htrans <= HTRANS_NONSEQ;
         req_i.hwrite <= tbl[ap].write;
         req_i.hsize  <= tbl[ap].size;
      end else begin
         req_i.haddr  <= '0;
         req_i.htrans <= HTRANS_IDLE;
         req_i.hwrite <= 1'b0;
         req_i.hsize  <= HSIZE_WORD;
      end
      if (dp >= 0 && tbl[dp].write) req_i.hwdata <= tbl[dp].wdata;
      else                          req_i.hwdata <= '0;
   endtask

   // returns on the edge that ends the data phase of entry dp
   task automatic finish_data_phase(input int dp, output logic hung);
      string    name;
      stim_t    e;
      logic     exp_err;
      int       low_cycles;
      byte_en_t be;
      hdata_t   exp_data;
      name       = (dp >= 0) ? tbl_name[dp] : "idle";
      e          = (dp >= 0) ? tbl[dp] : '0;
      exp_err    = e.flags[0];
      low_cycles = 0;
      hung       = 1'b0;
      @(negedge hclk_i);
      while (!rsp_o.hready && low_cycles < WAIT_LIMIT) begin
         check_value({name, " hresp while stalled"}, 32'd1, 32'(rsp_o.hresp));
         low_cycles++;
         @(negedge hclk_i);
      end
      if (!rsp_o.hready) begin
         timeouts++;
         $display("timeout: hready stayed low for %0d cycles in the data phase of %s",
                  WAIT_LIMIT, name);
         hung = 1'b1;
         return;
      end
      check_value({name, " stall cycles"}, exp_err ? 32'd1 : 32'd0, 32'(low_cycles));
      check_value({name, " hresp"}, exp_err ? 32'd1 : 32'd0, 32'(rsp_o.hresp));
      if (dp < 0 || (!exp_err && !e.write)) begin
         exp_data = (dp < 0) ? '0 : model[e.addr[9:8]][e.addr[7:2]];   // idle gives zero
         check_value({name, " hrdata"}, exp_data, rsp_o.hrdata);
      end
      if (dp >= 0 && !exp_err && e.write) begin
         be = lanes(e.size, e.addr[1:0]);
         for (int b = 0; b < 4; b++) begin
            if (be[b]) model[e.addr[9:8]][e.addr[7:2]][8*b +: 8] = e.wdata[8*b +: 8];
         end
      end
      @(posedge hclk_i);
   endtask

   task automatic fill_table();
      // name, address, write, size, data, {random, back to back, expect error}
      add_entry("wr_win0",    32'h4000_0010, 1'b1, HSIZE_WORD, 32'h0A0A_0001, 3'b000);
      add_entry("wr_win1",    32'h4000_0110, 1'b1, HSIZE_WORD, 32'h1B1B_0002, 3'b000);
      add_entry("wr_win2",    32'h4000_0210, 1'b1, HSIZE_WORD, 32'h2C2C_0003, 3'b000);
      add_entry("wr_win3",    32'h4000_0310, 1'b1, HSIZE_WORD, 32'h3D3D_0004, 3'b000);
      add_entry("rd_win0",    32'h4000_0010, 1'b0, HSIZE_WORD, 32'h0,         3'b000);
      add_entry("rd_win1",    32'h4000_0110, 1'b0, HSIZE_WORD, 32'h0,         3'b000);
      add_entry("rd_win2",    32'h4000_0210, 1'b0, HSIZE_WORD, 32'h0,         3'b000);
      add_entry("rd_win3",    32'h4000_0310, 1'b0, HSIZE_WORD, 32'h0,         3'b000);
      add_entry("wr_known0",  32'h4000_0020, 1'b1, HSIZE_WORD, 32'h1122_3344, 3'b000);
      add_entry("wr_byte0",   32'h4000_0020, 1'b1, HSIZE_BYTE, 32'hA1B2_C3D4, 3'b000);
      add_entry("wr_byte2",   32'h4000_0022, 1'b1, HSIZE_BYTE, 32'h55AA_55AA, 3'b000);
      add_entry("rd_bytes",   32'h4000_0020, 1'b0, HSIZE_WORD, 32'h0,         3'b000);
      add_entry("wr_known1",  32'h4000_0124, 1'b1, HSIZE_WORD, 32'h5566_7788, 3'b000);
      add_entry("wr_half_hi", 32'h4000_0126, 1'b1, HSIZE_HALF, 32'hCAFE_F00D, 3'b000);
      add_entry("wr_byte1",   32'h4000_0125, 1'b1, HSIZE_BYTE, 32'h0000_EE00, 3'b000);
      add_entry("rd_half",    32'h4000_0124, 1'b0, HSIZE_WORD, 32'h0,         3'b000);
      add_entry("rnd_wr",     32'h4000_0230, 1'b1, HSIZE_WORD, 32'h0,         3'b100);
      add_entry("rnd_rd",     32'h4000_0230, 1'b0, HSIZE_WORD, 32'h0,         3'b010);
      add_entry("pipe_wr0",   32'h4000_0040, 1'b1, HSIZE_WORD, 32'h0,         3'b100);
      add_entry("pipe_wr1",   32'h4000_0140, 1'b1, HSIZE_WORD, 32'h0,         3'b110);
      add_entry("pipe_wr2",   32'h4000_0240, 1'b1, HSIZE_WORD, 32'h0,         3'b110);
      add_entry("pipe_wr3",   32'h4000_0340, 1'b1, HSIZE_WORD, 32'h0,         3'b110);
      add_entry("pipe_rd3",   32'h4000_0340, 1'b0, HSIZE_WORD, 32'h0,         3'b010);
      add_entry("pipe_rd0",   32'h4000_0040, 1'b0, HSIZE_WORD, 32'h0,         3'b010);
      add_entry("pipe_rd2",   32'h4000_0240, 1'b0, HSIZE_WORD, 32'h0,         3'b010);
      add_entry("pipe_rd1",   32'h4000_0140, 1'b0, HSIZE_WORD, 32'h0,         3'b010);
      add_entry("err_rd",     32'h4000_0400, 1'b0, HSIZE_WORD, 32'h0,         3'b001);
      add_entry("after_rd",   32'h4000_0110, 1'b0, HSIZE_WORD, 32'h0,         3'b010);
      add_entry("err_wr",     32'h4000_0410, 1'b1, HSIZE_WORD, 32'hDEAD_BEEF, 3'b001);
      add_entry("after_wr",   32'h4000_0010, 1'b0, HSIZE_WORD, 32'h0,         3'b010);
      add_entry("err_zero",   32'h0000_0000, 1'b1, HSIZE_WORD, 32'hDEAD_BEEF, 3'b011);
      add_entry("after_zero", 32'h4000_0210, 1'b0, HSIZE_WORD, 32'h0,         3'b010);
   endtask

   //////////////////////////////////////////////////////////////////////
   // main sequence

   initial begin
      int   slots [$];
      int   ap;
      int   dp;
      logic hung;
      void'($urandom(32'h7a7f));
      rst_i    = 1'b1;
      req_i    = '0;
      errors   = 0;
      timeouts = 0;
      fill_table();

      repeat (2) @(posedge hclk_i);
      rst_i <= 1'b0;
      @(posedge hclk_i);   // one idle cycle
      @(negedge hclk_i);
      check_value("reset hready", 32'd1, 32'(rsp_o.hready));
      check_value("reset hresp", 32'd0, 32'(rsp_o.hresp));
      check_value("reset hrdata", 32'd0, rsp_o.hrdata);

      // idle address phase in front of every entry that is not back to back
      foreach (tbl[i]) begin
         if (!tbl[i].flags[1]) slots.push_back(-1);
         slots.push_back(i);
      end

      ap   = -1;
      hung = 1'b0;
      @(posedge hclk_i);
      while (!hung && (slots.size() > 0 || ap >= 0)) begin
         dp = ap;                                           // accepted at this edge
         ap = (slots.size() > 0) ? slots.pop_front() : -1;
         drive_bus(ap, dp);
         finish_data_phase(dp, hung);
      end

      $display("errors %0d timeouts %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* ahb_fabric_properties.sv */
// AHB fabric bus properties
// concurrent checks on the top-level response and the decoder select
`timescale 1ns/1ps
`default_nettype none

module ahb_fabric_properties #(
   parameter int NUM_SLAVES = 4
) (
   input logic                  hclk_i,
   input logic                  rst_i,
   input ahb_pkg::ahb_rsp_t     rsp_i,
   input logic [NUM_SLAVES-1:0] sel_i
);

   // stalled ERROR cycle, then the ready ERROR cycle
   a_err_two_cycle: assert property (@(posedge hclk_i) disable iff (rst_i)
      (!rsp_i.hready && rsp_i.hresp) |=> (rsp_i.hready && rsp_i.hresp))
      else $error("error response not followed by a ready ERROR cycle");

   // disjoint windows
   a_sel_onehot: assert property (@(posedge hclk_i) disable iff (rst_i)
      $onehot0(sel_i))
      else $error("decoder select has more than one bit set");

   a_ready_after_reset: assert property (@(posedge hclk_i)
      $fell(rst_i) |-> rsp_i.hready)
      else $error("hready low in the first cycle after reset");

endmodule

bind ahb_fabric_top ahb_fabric_properties #(
   .NUM_SLAVES ( NUM_SLAVES )
) u_properties (
   .hclk_i     ( hclk_i     ),
   .rst_i      ( rst_i      ),
   .rsp_i      ( rsp_o      ),
   .sel_i      ( sel        )
);

`default_nettype wire

/* ahb_fabric_top.sv */
// AHB-Lite slave fabric
// address decoder, a bank of SRAM slaves and the response mux
`timescale 1ns/1ps
`default_nettype none

module ahb_fabric_top #(
   parameter int NUM_SLAVES = 4,    // 1 .. soc_map_pkg::MAX_SLAVES
   parameter int MEM_WORDS  = 64    // per slave, power of two, at most 64
) (
   input  logic              hclk_i,
   input  logic              rst_i,
   input  ahb_pkg::ahb_req_t req_i,
   output ahb_pkg::ahb_rsp_t rsp_o
);

   import ahb_pkg::*;
   import soc_map_pkg::*;

   logic [NUM_SLAVES-1:0] sel;
   dsel_t                 dsel;
   ahb_rsp_t              slv_rsp [NUM_SLAVES];
   logic                  hready;

   assign hready = rsp_o.hready;   // bus HREADY back to every slave

   //////////////////////////////////////////////////////////////////////
   // decode

   ahb_addr_decoder #(
      .NUM_SLAVES ( NUM_SLAVES )
   ) u_decoder (
      .hclk_i     ( hclk_i     ),
      .rst_i      ( rst_i      ),
      .req_i      ( req_i      ),
      .hready_i   ( hready     ),
      .sel_o      ( sel        ),
      .dsel_o     ( dsel       )
   );

   //////////////////////////////////////////////////////////////////////
   // slave bank

   for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_sram
      ahb_sram_slave #(
         .MEM_WORDS ( MEM_WORDS  )
      ) u_sram (
         .hclk_i    ( hclk_i     ),
         .rst_i     ( rst_i      ),
         .hsel_i    ( sel[s]     ),
         .req_i     ( req_i      ),
         .hready_i  ( hready     ),
         .rsp_o     ( slv_rsp[s] )
      );
   end

   ahb_resp_mux #(
      .NUM_SLAVES ( NUM_SLAVES )
   ) u_resp_mux (
      .hclk_i     ( hclk_i     ),
      .rst_i      ( rst_i      ),
      .dsel_i     ( dsel       ),
      .slv_rsp_i  ( slv_rsp    ),
      .rsp_o      ( rsp_o      )
   );

endmodule

`default_nettype wire

/* ahb_resp_mux.sv */
// AHB-Lite response multiplexer
// forwards the data-phase slave's response and plays the default slave
// with a two cycle ERROR response for unmapped addresses
`timescale 1ns/1ps
`default_nettype none

module ahb_resp_mux #(
   parameter int NUM_SLAVES = 4
) (
   input  logic               hclk_i,
   input  logic               rst_i,
   input  soc_map_pkg::dsel_t dsel_i,
   input  ahb_pkg::ahb_rsp_t  slv_rsp_i [NUM_SLAVES],
   output ahb_pkg::ahb_rsp_t  rsp_o
);

   import ahb_pkg::*;
   import soc_map_pkg::*;

   typedef enum logic [1:0] {
      IDLE_OK,
      ERR_WAIT,
      ERR_LAST
   } err_state_t;

   err_state_t err_q;
   err_state_t err_d;
   err_state_t err_cur;

   //////////////////////////////////////////////////////////////////////
   // default slave

   // a fresh miss is first seen in its data phase, so the wait cycle
   // is entered straight from IDLE_OK
   always_comb begin
      err_cur = err_q;
      if (err_q == IDLE_OK && dsel_i.valid && dsel_i.miss) err_cur = ERR_WAIT;
   end

   always_comb begin
      rsp_o = '{hrdata: '0, hready: 1'b1, hresp: 1'b0};   // OKAY
      err_d = IDLE_OK;
      case (err_cur)
         ERR_WAIT: begin
            rsp_o.hready = 1'b0;   // stall the master
            rsp_o.hresp  = 1'b1;
            err_d        = ERR_LAST;
         end
         ERR_LAST: begin
            rsp_o.hresp  = 1'b1;
         end
         default: begin
            // mapped data phase, otherwise the OKAY above stands
            for (int i = 0; i < NUM_SLAVES; i++) begin
               if (dsel_i.valid && !dsel_i.miss && dsel_i.idx == slave_idx_t'(i)) begin
                  rsp_o = slv_rsp_i[i];
               end
            end
         end
      endcase
   end

   always_ff @(posedge hclk_i) begin
      if (rst_i) err_q <= IDLE_OK;
      else       err_q <= err_d;
   end

endmodule

`default_nettype wire

/* ahb_sram_slave.sv */
// AHB-Lite on-chip SRAM slave
// word organised, zero wait states, byte and halfword writes
// through byte lanes
`timescale 1ns/1ps
`default_nettype none

module ahb_sram_slave #(
   parameter int MEM_WORDS = 64
) (
   input  logic              hclk_i,
   input  logic              rst_i,
   input  logic              hsel_i,
   input  ahb_pkg::ahb_req_t req_i,
   input  logic              hready_i,
   output ahb_pkg::ahb_rsp_t rsp_o
);

   import ahb_pkg::*;

   localparam int AW = $clog2(MEM_WORDS);   // word address bits

   hdata_t          mem [MEM_WORDS];
   logic            accept;
   logic            we_q;
   logic [AW-1:0]   addr_q;
   byte_en_t        be_d;
   byte_en_t        be_q;

   //////////////////////////////////////////////////////////////////////
   // address phase capture

   assign accept = hsel_i && hready_i &&
                   ((req_i.htrans == HTRANS_NONSEQ) || (req_i.htrans == HTRANS_SEQ));

   // lanes from size and low address bits
   always_comb begin
      case (req_i.hsize)
         HSIZE_BYTE: be_d = byte_en_t'(4'b0001 << req_i.haddr[1:0]);
         HSIZE_HALF: be_d = req_i.haddr[1] ? 4'b1100 : 4'b0011;
         default:    be_d = 4'b1111;
      endcase
   end

   always_ff @(posedge hclk_i) begin
      if (rst_i) begin
         we_q <= 1'b0;
      end else if (hready_i) begin
         we_q <= accept && req_i.hwrite;    // one data phase only
      end
   end

   always_ff @(posedge hclk_i) begin
      if (accept) begin
         addr_q <= req_i.haddr[AW+1:2];
         be_q   <= be_d;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // data phase

   // write lands at the end of the data phase
   always_ff @(posedge hclk_i) begin
      if (we_q && hready_i) begin
         for (int b = 0; b < 4; b++) begin
            if (be_q[b]) mem[addr_q][8*b +: 8] <= req_i.hwdata[8*b +: 8];
         end
      end
   end

   assign rsp_o.hrdata = mem[addr_q];   // word read, lanes picked by master
   assign rsp_o.hready = 1'b1;
   assign rsp_o.hresp  = 1'b0;

endmodule

`default_nettype wire

/* ahb_addr_decoder.sv */
// AHB-Lite address decoder
// one-hot slave select in the address phase, registered selection
// for the data phase
`timescale 1ns/1ps
`default_nettype none

module ahb_addr_decoder #(
   parameter int NUM_SLAVES = 4
) (
   input  logic                   hclk_i,
   input  logic                   rst_i,
   input  ahb_pkg::ahb_req_t      req_i,
   input  logic                   hready_i,
   output logic [NUM_SLAVES-1:0]  sel_o,
   output soc_map_pkg::dsel_t     dsel_o
);

   import ahb_pkg::*;
   import soc_map_pkg::*;

   logic       active;
   logic       hit;
   slave_idx_t hit_idx;

   //////////////////////////////////////////////////////////////////////
   // address phase

   assign active = (req_i.htrans == HTRANS_NONSEQ) ||
                   (req_i.htrans == HTRANS_SEQ);

   // windows are disjoint, so at most one bit is set
   always_comb begin
      sel_o   = '0;
      hit_idx = '0;
      for (int i = 0; i < NUM_SLAVES; i++) begin
         if (active && ((req_i.haddr & SLAVE_MASK[i]) == SLAVE_BASE[i])) begin
            sel_o[i] = 1'b1;
            hit_idx  = slave_idx_t'(i);
         end
      end
   end

   assign hit = |sel_o;

   //////////////////////////////////////////////////////////////////////
   // data phase selection

   // only moves on an accepting edge; held while the bus stalls
   always_ff @(posedge hclk_i) begin
      if (rst_i) begin
         dsel_o <= '0;
      end else if (hready_i) begin
         dsel_o.valid <= active;             // idle or busy clears it
         dsel_o.miss  <= active && !hit;     // goes to the default slave
         dsel_o.idx   <= hit_idx;
      end
   end

endmodule

`default_nettype wire

/* soc_map_pkg.sv */
// SoC address map
// mask/base table of the slave windows and the data-phase select record
`default_nettype none

package soc_map_pkg;

   localparam int MAX_SLAVES = 4;

   typedef logic [1:0] slave_idx_t;

   // four 256 byte windows, a hit is (haddr & mask) == base
   localparam ahb_pkg::haddr_t SLAVE_BASE [MAX_SLAVES] = '{
      32'h4000_0000,
      32'h4000_0100,
      32'h4000_0200,
      32'h4000_0300
   };

   localparam ahb_pkg::haddr_t SLAVE_MASK [MAX_SLAVES] = '{
      32'hFFFF_FF00,
      32'hFFFF_FF00,
      32'hFFFF_FF00,
      32'hFFFF_FF00
   };

   // selection held by the decoder for the data phase
   typedef struct packed {
      logic       valid;   // a transfer is in its data phase
      logic       miss;    // no window matched
      slave_idx_t idx;
   } dsel_t;

endpackage

`default_nettype wire

/* ahb_pkg.sv */
// AHB-Lite bus definitions
// widths, transfer and size codes, request and response structs
`default_nettype none

package ahb_pkg;

   //////////////////////////////////////////////////////////////////////
   // widths with a meaning
   typedef logic [31:0] haddr_t;
   typedef logic [31:0] hdata_t;
   typedef logic [1:0]  htrans_t;
   typedef logic [2:0]  hsize_t;
   typedef logic [3:0]  byte_en_t;      // one bit per byte lane

   // transfer types
   localparam htrans_t HTRANS_IDLE   = 2'b00;
   localparam htrans_t HTRANS_BUSY   = 2'b01;
   localparam htrans_t HTRANS_NONSEQ = 2'b10;
   localparam htrans_t HTRANS_SEQ    = 2'b11;

   // transfer sizes, only up to a word on this bus
   localparam hsize_t HSIZE_BYTE = 3'b000;
   localparam hsize_t HSIZE_HALF = 3'b001;
   localparam hsize_t HSIZE_WORD = 3'b010;

   //////////////////////////////////////////////////////////////////////
   // master request, address phase fields plus data phase hwdata
   typedef struct packed {
      haddr_t  haddr;
      htrans_t htrans;
      logic    hwrite;
      hsize_t  hsize;
      hdata_t  hwdata;   // valid one cycle after its address phase
   } ahb_req_t;

   // slave response
   typedef struct packed {
      hdata_t hrdata;
      logic   hready;
      logic   hresp;     // 1 = ERROR
   } ahb_rsp_t;

endpackage

`default_nettype wire
